/* files.f */
tcp_conn_pkg.sv
tcp_conn_regs.sv
tcp_seg_classify.sv
tcp_conn_fsm.sv
tcp_seg_builder.sv
tcp_conn_timer.sv
tcp_conn_top.sv
tb_tcp_conn.sv

/* Makefile */
TOP = tb_tcp_conn

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module $(TOP) --Mdir obj_dir -o sim -f files.f

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* tb_tcp_conn.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tcp_conn
  import tcp_conn_pkg::*;
;

  localparam int CLK_NS       = 4;
  localparam int CONN_TIMEOUT = 200;
  localparam int WINDOW_SIZE  = 4000;
  localparam int SEG_WAIT     = 64;  // Cycles to wait for tx_valid
  localparam int MAX_STALL    = 12;  // Longest run of tx_ready low
  localparam int N_TESTS      = 5;
  localparam int TEST_CYCLES  = 300; // Budget per test
  localparam int WATCHDOG_NS  = CLK_NS * (16 + N_TESTS * TEST_CYCLES + 4 * CONN_TIMEOUT);

  logic        clk;
  logic        rst_rec;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  rx_seg_t     rx_seg;
  tcp_hdr_t    tx_seg;
  logic        tx_valid;
  logic        tx_ready;

  logic [31:0] rng_state = 32'h197c72b4;
  string       test_name;
  int          test_errs;
  int          checks;
  int          errors;
  int          stall_pct;
  int          cycle;

  // Reference model of the connection, peer side included
  logic [15:0] m_loc_port;
  logic [15:0] m_rem_port;
  logic [31:0] m_rem_ip;
  logic [31:0] m_isn;
  logic [31:0] m_loc_seq;
  logic [31:0] m_loc_ack;
  logic [31:0] peer_seq;

  tcp_conn_top #(
    .CONN_TIMEOUT (CONN_TIMEOUT),
    .WINDOW_SIZE  (WINDOW_SIZE)
  ) uut (
    .clk      (clk),
    .rst_rec  (rst_rec),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .rx_seg   (rx_seg),
    .tx_seg   (tx_seg),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_pct();
    return int'((next_random() >> 16) % 32'd100); // Upper bits are the better ones
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
    test_errs++;
  endtask

  // Expected header, built from the model TCB
  function automatic tcp_hdr_t model_hdr(input logic [7:0] flags);
    tcp_hdr_t h;
    h.src_port  = m_loc_port;
    h.dst_port  = m_rem_port;
    h.rem_ip    = m_rem_ip;
    h.flags.raw = flags;
    h.wnd_size  = 16'(WINDOW_SIZE);
    h.seq_num   = (flags == flag_syn) ? m_isn : m_loc_seq;
    h.ack_num   = (flags == flag_syn) ? 32'd0 : m_loc_ack;
    return h;
  endfunction

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    check_value("pready", 32'd1, 32'(pready));
    data    = prdata; // Access phase, pready is tied high
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_status(input conn_status_e exp, input logic [1:0] ctrl);
    logic [31:0] rd;
    apb_read(4'h0, rd);
    check_value("status", 32'(exp), 32'(rd[6:4]));
    check_value("ctrl", 32'(ctrl), 32'(rd[1:0]));
  endtask

  task automatic send_seg(input logic [7:0] flags, input logic [15:0] dport,
                          input logic [31:0] seq, input logic [31:0] ack);
    @(negedge clk);
    rx_seg.valid     = 1'b1;
    rx_seg.src_ip    = m_rem_ip;
    rx_seg.src_port  = m_rem_port;
    rx_seg.dst_port  = dport;
    rx_seg.seq_num   = seq;
    rx_seg.ack_num   = ack;
    rx_seg.flags.raw = flags;
    rx_seg.wnd_size  = 16'd8192;
    @(negedge clk);
    rx_seg = '0;  // Single-cycle strobe
  endtask

  // Takes one segment with random tx_ready stalls, watching the header hold still
  task automatic take_seg(output tcp_hdr_t hdr, output logic got);
    int       wait_cyc;
    int       stall_cyc;
    logic     held;
    logic     ready;
    tcp_hdr_t first;
    wait_cyc  = 0;
    stall_cyc = 0;
    held      = 1'b0;
    got       = 1'b0;
    hdr       = '0;
    first     = '0;
    while (!got && wait_cyc < SEG_WAIT) begin
      @(negedge clk);
      if (tx_valid) begin
        if (held && tx_seg !== first) note_error("header changed while tx_ready was low");
        first    = tx_seg;
        held     = 1'b1;
        ready    = (rand_pct() >= stall_pct) || (stall_cyc >= MAX_STALL);
        tx_ready = ready;
        if (ready) begin
          hdr = tx_seg;
          got = 1'b1;
        end else begin
          stall_cyc++;
        end
      end else begin
        if (held) note_error("tx_valid dropped while tx_ready was low");
        held = 1'b0;
        wait_cyc++;
      end
    end
    if (got) @(negedge clk); // Transfer happened on the edge in between
    tx_ready = 1'b0;
    if (!got) note_error($sformatf("no segment sent within %0d cycles", SEG_WAIT));
  endtask

  task automatic expect_seg(input string what, input logic [7:0] flags);
    tcp_hdr_t hdr;
    tcp_hdr_t exp;
    logic     got;
    take_seg(hdr, got);
    exp = model_hdr(flags);
    if (got) begin
      check_value({what, ".src_port"}, 32'(exp.src_port), 32'(hdr.src_port));
      check_value({what, ".dst_port"}, 32'(exp.dst_port), 32'(hdr.dst_port));
      check_value({what, ".seq"}, exp.seq_num, hdr.seq_num);
      check_value({what, ".ack"}, exp.ack_num, hdr.ack_num);
      check_value({what, ".flags"}, 32'(exp.flags.raw), 32'(hdr.flags.raw));
      check_value({what, ".wnd"}, 32'(exp.wnd_size), 32'(hdr.wnd_size));
      check_value({what, ".rem_ip"}, exp.rem_ip, hdr.rem_ip);
    end
  endtask

  task automatic expect_no_segment(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (tx_valid) note_error("segment sent although none was expected");
    end
  endtask

  ////////////////////////////////////////
  // Connection sequences
  ////////////////////////////////////////
  task automatic new_config();
    logic [31:0] rd;
    m_loc_port = 16'(next_random() >> 8);
    m_rem_port = 16'(next_random() >> 8);
    m_rem_ip   = next_random();
    m_isn      = next_random();
    peer_seq   = next_random();
    apb_write(4'h4, {m_rem_port, m_loc_port});
    apb_write(4'h8, m_rem_ip);
    apb_write(4'hC, m_isn);
    apb_read(4'h4, rd); // Config registers read back what was written
    check_value("ports", {m_rem_port, m_loc_port}, rd);
    apb_read(4'h8, rd);
    check_value("rem_ip", m_rem_ip, rd);
    apb_read(4'hC, rd);
    check_value("isn", m_isn, rd);
  endtask

  task automatic active_open();
    apb_write(4'h0, 32'h1);
    m_loc_seq = m_isn;
    m_loc_ack = 32'd0;
    expect_seg("syn", flag_syn);
    send_seg(flag_syn | flag_ack, m_loc_port, peer_seq, m_isn + 32'd1);
    m_loc_seq = m_isn + 32'd1;     // SYN used one number
    m_loc_ack = peer_seq + 32'd1;
    expect_seg("ack", flag_ack);
    check_status(conn_connected, 2'b01);
  endtask

  task automatic rst_close();
    send_seg(flag_rst, m_loc_port, m_loc_ack, 32'd0);
    expect_seg("rst_ack", flag_rst | flag_ack);
    check_status(conn_closed, 2'b01);
    apb_write(4'h0, 32'h0);
  endtask

  task automatic begin_test(input string name, input int pct);
    test_name = name;
    test_errs = 0;
    stall_pct = pct;
  endtask

  task automatic end_test();
    $display("test %-18s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "bad", test_errs);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    int          start;
    logic        closed;
    rst_rec  = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    rx_seg   = '0;
    tx_ready = 1'b0;
    cycle    = 0;
    checks   = 0;
    errors   = 0;
    repeat (16) @(negedge clk);
    rst_rec = 1'b0;

    begin_test("active_open", 20);
    check_value("tx_valid", 32'd0, 32'(tx_valid)); // Nothing pending out of reset
    check_status(conn_closed, 2'b00);
    new_config();
    active_open();
    end_test();

    begin_test("active_close", 20);
    apb_write(4'h0, 32'h0);
    expect_seg("fin_ack", flag_fin | flag_ack);
    send_seg(flag_ack, m_loc_port, m_loc_ack, m_loc_seq + 32'd1);
    send_seg(flag_fin | flag_ack, m_loc_port, m_loc_ack, m_loc_seq + 32'd1);
    m_loc_ack = m_loc_ack + 32'd1; // Peer FIN used one number
    expect_seg("ack", flag_ack);
    check_status(conn_closed, 2'b00);
    end_test();

    begin_test("passive_open", 20);
    new_config();
    apb_write(4'h0, 32'h2);
    check_status(conn_listening, 2'b10);
    send_seg(flag_syn, m_loc_port + 16'd1, peer_seq, 32'd0); // Wrong port
    expect_no_segment(24);
    check_status(conn_listening, 2'b10);
    send_seg(flag_syn, m_loc_port, peer_seq, 32'd0);
    m_loc_seq = m_isn;
    m_loc_ack = peer_seq + 32'd1;
    expect_seg("syn_ack", flag_syn | flag_ack);
    send_seg(flag_ack, m_loc_port, m_loc_ack, m_isn + 32'd1);
    m_loc_seq = m_isn + 32'd1;
    check_status(conn_connected, 2'b10);
    end_test();

    begin_test("passive_close_rst", 20);
    send_seg(flag_fin | flag_ack, m_loc_port, m_loc_ack, m_loc_seq);
    m_loc_ack = m_loc_ack + 32'd1;
    expect_seg("ack", flag_ack);
    expect_seg("fin_ack", flag_fin | flag_ack);
    send_seg(flag_ack, m_loc_port, m_loc_ack, m_loc_seq + 32'd1);
    check_status(conn_closed, 2'b10);
    apb_write(4'h0, 32'h0);
    new_config();
    active_open();
    rst_close();
    end_test();

    begin_test("stall_timeout", 70);
    new_config();
    active_open();
    rst_close();
    apb_write(4'h0, 32'h1);
    start     = cycle;
    m_loc_seq = m_isn;
    m_loc_ack = 32'd0;
    expect_seg("syn", flag_syn);
    check_status(conn_connecting, 2'b01);
    closed = 1'b0;
    while (!closed && (cycle - start) <= CONN_TIMEOUT + 8) begin // Peer stays silent
      apb_read(4'h0, rd);
      closed = (rd[6:4] == conn_closed);
    end
    if (!closed) begin
      note_error($sformatf("status not closed %0d cycles after connect", CONN_TIMEOUT + 8));
    end else if ((cycle - start) < CONN_TIMEOUT) begin
      note_error($sformatf("connection closed after only %0d cycles", cycle - start));
    end
    check_value("tx_valid", 32'd0, 32'(tx_valid));
    apb_write(4'h0, 32'h0);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tcp_conn_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_conn_top
  import tcp_conn_pkg::*;
#(
  parameter int CONN_TIMEOUT = 10000,
  parameter int WINDOW_SIZE  = 4000
) (
  input  logic        clk,
  input  logic        rst_rec,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  input  rx_seg_t     rx_seg,
  output tcp_hdr_t    tx_seg,
  output logic        tx_valid,
  input  logic        tx_ready
);

  conn_cfg_t    cfg;
  conn_status_e status;
  rx_evt_t      evt;
  tcb_t         tcb;
  seg_kind_e    seg_kind;
  logic         seg_req;
  logic         tx_done;
  logic         con_en;
  logic         dcn_en;
  logic         conn_clear;  // Clears timers and any held segment
  logic         con_expired;
  logic         dcn_expired;

  ////////////////////////////////////////
  // Control path
  ////////////////////////////////////////
  tcp_conn_regs regs (
    .clk     (clk),
    .rst_rec (rst_rec),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .status  (status),
    .cfg     (cfg)
  );

  tcp_seg_classify classify (
    .clk      (clk),
    .rst_rec  (rst_rec),
    .rx_seg   (rx_seg),
    .loc_port (cfg.loc_port),
    .tcb      (tcb),
    .evt      (evt)
  );

  tcp_conn_fsm fsm (
    .clk         (clk),
    .rst_rec     (rst_rec),
    .cfg         (cfg),
    .evt         (evt),
    .tx_done     (tx_done),
    .con_expired (con_expired),
    .dcn_expired (dcn_expired),
    .seg_req     (seg_req),
    .seg_kind    (seg_kind),
    .tcb         (tcb),
    .con_en      (con_en),
    .dcn_en      (dcn_en),
    .tmr_clear   (conn_clear),
    .status      (status)
  );

  ////////////////////////////////////////
  // Segment output and timeouts
  ////////////////////////////////////////
  tcp_seg_builder #(
    .WINDOW_SIZE (WINDOW_SIZE)
  ) builder (
    .clk      (clk),
    .rst_rec  (rst_rec),
    .clear    (conn_clear),
    .seg_req  (seg_req),
    .seg_kind (seg_kind),
    .tcb      (tcb),
    .isn      (cfg.isn),
    .tx_seg   (tx_seg),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_done  (tx_done)
  );

  tcp_conn_timer #(
    .CONN_TIMEOUT (CONN_TIMEOUT)
  ) con_tmr (
    .clk     (clk),
    .rst_rec (rst_rec),
    .en      (con_en),
    .clear   (conn_clear),
    .expired (con_expired)
  );

  tcp_conn_timer #(
    .CONN_TIMEOUT (CONN_TIMEOUT)
  ) dcn_tmr (
    .clk     (clk),
    .rst_rec (rst_rec),
    .en      (dcn_en),
    .clear   (conn_clear),
    .expired (dcn_expired)
  );

endmodule

`default_nettype wire

/* tcp_conn_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_conn_timer #(
  parameter int CONN_TIMEOUT = 10000
) (
  input  logic clk,
  input  logic rst_rec,
  input  logic en,
  input  logic clear,
  output logic expired
);

  localparam int CW = $clog2(CONN_TIMEOUT + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst_rec || clear || !en) begin
      cnt     <= '0; // Only consecutive enabled cycles count
      expired <= 1'b0;
    end else if (cnt == CW'(CONN_TIMEOUT - 1)) begin
      cnt     <= '0; // Start over after firing
      expired <= 1'b1;
    end else begin
      cnt     <= cnt + 1'b1;
      expired <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* tcp_seg_builder.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_seg_builder
  import tcp_conn_pkg::*;
#(
  parameter int WINDOW_SIZE = 4000
) (
  input  logic        clk,
  input  logic        rst_rec,
  input  logic        clear,
  input  logic        seg_req,
  input  seg_kind_e   seg_kind,
  input  tcb_t        tcb,
  input  logic [31:0] isn,
  output tcp_hdr_t    tx_seg,
  output logic        tx_valid,
  input  logic        tx_ready,
  output logic        tx_done
);

  tcp_hdr_t hdr_nxt;

  always_comb begin
    hdr_nxt.rem_ip   = tcb.rem_ip;
    hdr_nxt.src_port = tcb.loc_port;
    hdr_nxt.dst_port = tcb.rem_port;
    hdr_nxt.seq_num  = tcb.loc_seq;
    hdr_nxt.ack_num  = tcb.loc_ack;
    hdr_nxt.wnd_size = 16'(WINDOW_SIZE);
    case (seg_kind)
      seg_syn: begin
        hdr_nxt.flags.raw = flag_syn;
        hdr_nxt.seq_num   = isn;   // Initial sequence straight from config
        hdr_nxt.ack_num   = '0;
      end
      seg_syn_ack: hdr_nxt.flags.raw = flag_syn | flag_ack;
      seg_fin_ack: hdr_nxt.flags.raw = flag_fin | flag_ack;
      seg_rst_ack: hdr_nxt.flags.raw = flag_rst | flag_ack;
      default:     hdr_nxt.flags.raw = flag_ack;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_rec || clear) begin
      tx_valid <= 1'b0; // Drops even while stalled
    end else if (seg_req) begin
      tx_valid <= 1'b1;
    end else if (tx_done) begin
      tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (seg_req) tx_seg <= hdr_nxt;
  end

  assign tx_done = tx_valid && tx_ready; // Transfer cycle

  a_hold_stable : assert property (
    @(posedge clk) disable iff (rst_rec || clear)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_seg))
  ) else $error("tx_seg changed under back-pressure");

endmodule

`default_nettype wire

/* tcp_conn_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_conn_fsm
  import tcp_conn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_rec,
  input  conn_cfg_t    cfg,
  input  rx_evt_t      evt,
  input  logic         tx_done,
  input  logic         con_expired,
  input  logic         dcn_expired,
  output logic         seg_req,
  output seg_kind_e    seg_kind,
  output tcb_t         tcb,
  output logic         con_en,
  output logic         dcn_en,
  output logic         tmr_clear,
  output conn_status_e status
);

  typedef enum logic [4:0] {
    st_closed, st_listen,
    st_send_syn, st_syn_sent, st_send_ack, st_ack_sent,
    st_send_syn_ack, st_syn_ack_sent,
    st_established,
    st_send_fin, st_fin_wait1, st_fin_wait2, st_last_ack,
    st_send_dcn_ack, st_dcn_ack_sent,
    st_send_rst, st_rst_sent
  } state_e;

  state_e state;
  logic   is_server;  // Passive open
  logic   passive_cl; // Peer started the close
  logic   pend;       // Segment handed to the builder, not yet taken
  logic   conn_clear;
  logic   hold_off;   // Control bits must drop before reopening
  logic   usr_drop;
  logic   close_done;

  assign usr_drop   = is_server ? !cfg.listen : !cfg.connect;
  assign close_done = (state == st_dcn_ack_sent && tx_done && !passive_cl) ||
                      (state == st_last_ack && evt.ack_seen) ||
                      (state == st_rst_sent && tx_done);
  assign tmr_clear  = conn_clear;

  assign con_en = state inside {st_send_syn, st_syn_sent, st_send_ack, st_ack_sent,
                                st_send_syn_ack, st_syn_ack_sent};
  assign dcn_en = state inside {st_send_fin, st_fin_wait1, st_fin_wait2, st_last_ack,
                                st_send_dcn_ack, st_dcn_ack_sent, st_send_rst, st_rst_sent};

  always_comb begin
    case (state)
      st_closed:      status = conn_closed;
      st_listen:      status = conn_listening;
      st_established: status = conn_connected;
      default:        status = con_en ? conn_connecting : conn_disconnecting;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_rec || conn_clear) begin
      state      <= st_closed;
      tcb        <= '0;
      is_server  <= 1'b0;
      passive_cl <= 1'b0;
      seg_req    <= 1'b0;
      seg_kind   <= seg_syn;
    end else begin
      seg_req <= 1'b0;
      case (state)
        st_closed: begin
          if (!hold_off && cfg.listen) begin
            is_server    <= 1'b1;
            tcb.loc_port <= cfg.loc_port;
            state        <= st_listen;
          end else if (!hold_off && cfg.connect) begin
            is_server    <= 1'b0;
            tcb.rem_ip   <= cfg.rem_ip;
            tcb.loc_port <= cfg.loc_port;
            tcb.rem_port <= cfg.rem_port;
            tcb.loc_seq  <= cfg.isn;
            tcb.loc_ack  <= '0; // No peer seq yet
            state        <= st_send_syn;
          end
        end
        ////////////////////////////////////////
        // Active open
        ////////////////////////////////////////
        st_send_syn: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_syn;
          state    <= st_syn_sent;
        end
        st_syn_sent: if (evt.syn_ack_seen) begin
          tcb.loc_seq <= tcb.loc_seq + 32'd1; // SYN takes one number
          tcb.loc_ack <= evt.peer_seq + 32'd1;
          state       <= st_send_ack;
        end
        st_send_ack: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_ack;
          state    <= st_ack_sent;
        end
        st_ack_sent: if (tx_done) state <= st_established;
        ////////////////////////////////////////
        // Passive open
        ////////////////////////////////////////
        st_listen: begin
          if (!cfg.listen) begin
            state <= st_closed;
          end else if (evt.syn_seen) begin
            tcb.rem_ip   <= evt.peer_ip;
            tcb.rem_port <= evt.peer_port;
            tcb.loc_seq  <= cfg.isn;
            tcb.loc_ack  <= evt.peer_seq + 32'd1;
            state        <= st_send_syn_ack;
          end
        end
        st_send_syn_ack: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_syn_ack;
          state    <= st_syn_ack_sent;
        end
        st_syn_ack_sent: if (evt.hs_ack_seen) begin
          tcb.loc_seq <= tcb.loc_seq + 32'd1;
          state       <= st_established;
        end
        st_established: begin
          if (evt.rst_seen) begin
            state <= st_send_rst;
          end else if (evt.fin_seen) begin
            passive_cl  <= 1'b1;
            tcb.loc_ack <= tcb.loc_ack + 32'd1; // FIN takes one number
            state       <= st_send_dcn_ack;
          end else if (usr_drop) begin
            state <= st_send_fin;
          end
        end
        ////////////////////////////////////////
        // Close and reset
        ////////////////////////////////////////
        st_send_fin: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_fin_ack;
          state    <= passive_cl ? st_last_ack : st_fin_wait1;
        end
        st_fin_wait1: begin
          if (evt.fin_seen) begin // FIN|ACK in one segment
            tcb.loc_ack <= tcb.loc_ack + 32'd1;
            state       <= st_send_dcn_ack;
          end else if (evt.ack_seen) begin
            state <= st_fin_wait2;
          end
        end
        st_fin_wait2: if (evt.fin_seen) begin
          tcb.loc_ack <= tcb.loc_ack + 32'd1;
          state       <= st_send_dcn_ack;
        end
        st_send_dcn_ack: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_ack;
          state    <= st_dcn_ack_sent;
        end
        st_dcn_ack_sent: if (tx_done && passive_cl) state <= st_send_fin;
        st_send_rst: if (!pend) begin
          seg_req  <= 1'b1;
          seg_kind <= seg_rst_ack;
          state    <= st_rst_sent;
        end
        default: ; // Last ACK and RST sent wait here for conn_clear
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_rec || conn_clear) pend <= 1'b0;
    else if (seg_req)          pend <= 1'b1;
    else if (tx_done)          pend <= 1'b0;
  end

  // Timeouts and finished closes all funnel into one clear
  always_ff @(posedge clk) begin
    if (rst_rec) conn_clear <= 1'b0;
    else         conn_clear <= con_expired || dcn_expired || close_done;
  end

  always_ff @(posedge clk) begin
    if (rst_rec)                          hold_off <= 1'b0;
    else if (conn_clear)                  hold_off <= 1'b1;
    else if (!cfg.connect && !cfg.listen) hold_off <= 1'b0;
  end

  // Builder must only finish a segment that is still pending here
  a_done_pending : assert property (
    @(posedge clk) disable iff (rst_rec)
    tx_done |-> pend
  ) else $error("segment transfer without a pending request");

endmodule

`default_nettype wire

/* tcp_seg_classify.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_seg_classify
  import tcp_conn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_rec,
  input  rx_seg_t     rx_seg,
  input  logic [15:0] loc_port,
  input  tcb_t        tcb,
  output rx_evt_t     evt
);

  logic lsn_hit;    // Addressed to the listening port
  logic con_hit;    // Belongs to the current connection
  logic is_syn;     // Bare SYN, nothing else set
  logic is_syn_ack;
  logic seq_match;  // Peer seq lines up with what we acknowledged

  assign lsn_hit = rx_seg.valid && (rx_seg.dst_port == loc_port);
  assign con_hit = rx_seg.valid &&
                   (rx_seg.src_port == tcb.rem_port) &&
                   (rx_seg.dst_port == tcb.loc_port);

  // Raw view for the exact SYN match, named bits for the rest
  assign is_syn     = (rx_seg.flags.raw == flag_syn);
  assign is_syn_ack = rx_seg.flags.bits.syn && rx_seg.flags.bits.ack;
  assign seq_match  = (rx_seg.seq_num == tcb.loc_ack);

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      evt <= '0;
    end else begin
      evt.syn_seen     <= lsn_hit && is_syn;
      evt.syn_ack_seen <= lsn_hit && is_syn_ack;
      evt.hs_ack_seen  <= con_hit && rx_seg.flags.bits.ack && seq_match;
      evt.ack_seen     <= con_hit && rx_seg.flags.bits.ack;
      evt.fin_seen     <= con_hit && rx_seg.flags.bits.fin;
      evt.rst_seen     <= con_hit && rx_seg.flags.bits.rst;
      if (rx_seg.valid) begin
        evt.peer_seq  <= rx_seg.seq_num;  // Captured with every segment
        evt.peer_port <= rx_seg.src_port;
        evt.peer_ip   <= rx_seg.src_ip;
      end
    end
  end

endmodule

`default_nettype wire

/* tcp_conn_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_conn_regs
  import tcp_conn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_rec,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [3:0]   paddr,
  input  logic [31:0]  pwdata,
  output logic [31:0]  prdata,
  output logic         pready,
  input  conn_status_e status,
  output conn_cfg_t    cfg
);

  logic       wr_en;
  logic [1:0] reg_sel; // Word index, byte offset ignored

  assign reg_sel = paddr[3:2];
  assign wr_en   = psel && penable && pwrite; // Access phase of a write
  assign pready  = 1'b1;                      // No wait states

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        2'd0: begin
          cfg.connect <= pwdata[0];
          cfg.listen  <= pwdata[1];
        end
        2'd1: begin
          cfg.loc_port <= pwdata[15:0];
          cfg.rem_port <= pwdata[31:16];
        end
        2'd2:    cfg.rem_ip <= pwdata;
        default: cfg.isn    <= pwdata;
      endcase
    end
  end

  // Read mux, status sits above the control bits
  always_comb begin
    case (reg_sel)
      2'd0:    prdata = {25'd0, status, 2'b00, cfg.listen, cfg.connect};
      2'd1:    prdata = {cfg.rem_port, cfg.loc_port};
      2'd2:    prdata = cfg.rem_ip;
      default: prdata = cfg.isn;
    endcase
  end

  // APB master must keep psel through the access phase
  a_penable_psel : assert property (
    @(posedge clk) disable iff (rst_rec)
    penable |-> psel
  ) else $error("penable without psel");

endmodule

`default_nettype wire

/* tcp_conn_pkg.sv */
`default_nettype none

package tcp_conn_pkg;

  // Named view of the TCP flags byte, MSB first
  typedef struct packed {
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flag_bits_t;

  typedef union packed {
    logic [7:0]     raw;  // Exact matches
    tcp_flag_bits_t bits; // Single flag tests
  } tcp_flags_u;

  localparam logic [7:0] flag_fin = 8'h01;
  localparam logic [7:0] flag_syn = 8'h02;
  localparam logic [7:0] flag_rst = 8'h04;
  localparam logic [7:0] flag_ack = 8'h10;

  // Outgoing control segment header
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    tcp_flags_u  flags;
    logic [15:0] wnd_size;
    logic [31:0] rem_ip;   // Addressing only, not sent in the header
  } tcp_hdr_t;

  // Received segment strobe
  typedef struct packed {
    logic        valid;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    tcp_flags_u  flags;
    logic [15:0] wnd_size;
  } rx_seg_t;

  typedef struct packed {
    logic        connect;
    logic        listen;
    logic [15:0] loc_port;
    logic [15:0] rem_port;
    logic [31:0] rem_ip;
    logic [31:0] isn;
  } conn_cfg_t;

  typedef struct packed {
    logic        syn_seen;
    logic        syn_ack_seen;
    logic        hs_ack_seen;
    logic        ack_seen;
    logic        fin_seen;
    logic        rst_seen;
    logic [31:0] peer_seq;
    logic [15:0] peer_port;
    logic [31:0] peer_ip;
  } rx_evt_t;

  typedef enum logic [2:0] {
    conn_closed        = 3'd0,
    conn_listening     = 3'd1,
    conn_connecting    = 3'd2,
    conn_connected     = 3'd3,
    conn_disconnecting = 3'd4
  } conn_status_e;

  typedef enum logic [2:0] {
    seg_syn,
    seg_syn_ack,
    seg_ack,
    seg_fin_ack,
    seg_rst_ack
  } seg_kind_e;

  // Transmission control block
  typedef struct packed {
    logic [31:0] rem_ip;
    logic [15:0] loc_port;
    logic [15:0] rem_port;
    logic [31:0] loc_seq;
    logic [31:0] loc_ack;
  } tcb_t;

endpackage

`default_nettype wire
